// ==== vlog.f ====
hdl/rom_pkg.sv
hdl/rom_slot_rq.sv
hdl/rom_slot_arbiter.sv
hdl/sdram_rd_ctrl.sv
hdl/rom_subsys_top.sv
testbench/mem_model.sv
testbench/rom_tb.sv

// ==== Makefile ====
# Verilator build and run for the ROM access subsystem testbench

SRCS := $(shell cat vlog.f)

obj_dir/Vrom_tb: vlog.f $(SRCS)
	verilator --binary --timing --top-module rom_tb -f vlog.f -o Vrom_tb

.PHONY: run clean

run: obj_dir/Vrom_tb
	@out=$$(./obj_dir/Vrom_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^All tests passed$$"

clean:
	rm -rf obj_dir

// ==== testbench/rom_tb.sv ====
/* Testbench for rom_subsys_top: three random slot streams against a
   reference model of the caches, arbiter and refresh windows. */
`timescale 1ns/1ps
`default_nettype none

module rom_tb;

    import rom_pkg::*;

    localparam int NREQ  = 300;
    localparam int LIMIT = NREQ * 40;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] cur_addr [3];
    logic        cur_cs [3];
    wire  [7:0]  slot0_dout;
    wire  [15:0] slot1_dout;
    wire  [31:0] slot2_dout;
    wire         slot0_ok;
    wire         slot1_ok;
    wire         slot2_ok;
    wire         mem_rd;
    wire  [21:0] mem_addr;
    wire         mem_valid;
    wire  [31:0] mem_data;

    logic [15:0] lfsr;
    int          cyc;
    int          errors;
    int          count [3];
    logic        busy [3];
    logic        done_flag [3];
    logic        fresh [3];
    logic        hit_exp [3];
    logic        filled [3];
    logic        last_valid [3];
    logic [31:0] last_word [3];
    int          pres_cyc [3];
    int          gap [3];
    int          rd_snap [3];
    int          rd_cnt [int];
    int          sel;
    logic        inflight;
    logic        rdy_pend;

    always #5 clk = ~clk;

    rom_subsys_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .slot0_addr (cur_addr[0][9:0]),
        .slot1_addr (cur_addr[1][8:0]),
        .slot2_addr (cur_addr[2][7:0]),
        .slot0_cs   (cur_cs[0]),
        .slot1_cs   (cur_cs[1]),
        .slot2_cs   (cur_cs[2]),
        .slot0_dout (slot0_dout),
        .slot1_dout (slot1_dout),
        .slot2_dout (slot2_dout),
        .slot0_ok   (slot0_ok),
        .slot1_ok   (slot1_ok),
        .slot2_ok   (slot2_ok),
        .mem_rd     (mem_rd),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data)
    );

    mem_model mem_i (
        .clk       (clk),
        .rst       (rst),
        .mem_rd    (mem_rd),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_data  (mem_data)
    );

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], take_bit()};
        end
        return v;
    endfunction

    // same mixing as the memory model holds
    function automatic logic [31:0] model_word(input logic [31:0] a);
        logic [31:0] x;
        x = a * 32'h9E3779B1;
        return x ^ (x >> 15) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic int lane_shift(input int n);
        return (n == 0) ? 2 : (n == 1) ? 1 : 0;
    endfunction

    function automatic logic [31:0] slot_word(input int n, input logic [31:0] a);
        logic [31:0] base;
        base = (n == 0) ? 32'h0 : (n == 1) ? 32'h1000 : 32'h2000;
        return base + (a >> lane_shift(n));
    endfunction

    // little-endian lane of the model word
    function automatic logic [31:0] expected_lane(input int n, input logic [31:0] a);
        logic [31:0] w;
        w = model_word(slot_word(n, a));
        if (n == 0) begin
            return (w >> {a[1:0], 3'b000}) & 32'hFF;
        end else if (n == 1) begin
            return (w >> {a[0], 4'b0000}) & 32'hFFFF;
        end
        return w;
    endfunction

    function automatic logic [31:0] dout_of(input int n);
        return (n == 0) ? {24'h0, slot0_dout} : (n == 1) ? {16'h0, slot1_dout} : slot2_dout;
    endfunction

    function automatic logic ok_of(input int n);
        return (n == 0) ? slot0_ok : (n == 1) ? slot1_ok : slot2_ok;
    endfunction

    function automatic int reads_of(input logic [31:0] w);
        return rd_cnt.exists(int'(w)) ? rd_cnt[int'(w)] : 0;
    endfunction

    task automatic present_request(input int n);
        logic [31:0] a;
        int aw;
        aw = 10 - n;
        // half the time stay inside the previous word
        if (last_valid[n] && take_bit()) begin
            a = cur_addr[n] >> lane_shift(n);
            a = (a << lane_shift(n)) | rand_bits(lane_shift(n));
        end else begin
            a = rand_bits(aw);
        end
        cur_addr[n] = a;
        cur_cs[n]   = 1'b1;
        busy[n]     = 1'b1;
        fresh[n]    = 1'b1;
        filled[n]   = 1'b0;
        pres_cyc[n] = cyc;
        hit_exp[n]  = last_valid[n] && (slot_word(n, a) == last_word[n]);
        rd_snap[n]  = reads_of(slot_word(n, a));
    endtask

    task automatic drive_slot(input int n);
        if (done_flag[n]) begin
            done_flag[n] = 1'b0;
            cur_cs[n]    = 1'b0;
            gap[n]       = int'(rand_bits(2));
        end
        if (!busy[n] && count[n] < NREQ) begin
            if (gap[n] > 0) begin
                gap[n] = gap[n] - 1;
            end else begin
                present_request(n);
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        lfsr     = 16'd38833;
        cyc      = 0;
        errors   = 0;
        sel      = -1;
        inflight = 1'b0;
        rdy_pend = 1'b0;
        for (int n = 0; n < 3; n++) begin
            cur_addr[n]   = 32'h0;
            cur_cs[n]     = 1'b0;
            count[n]      = 0;
            busy[n]       = 1'b0;
            done_flag[n]  = 1'b0;
            fresh[n]      = 1'b0;
            hit_exp[n]    = 1'b0;
            filled[n]     = 1'b0;
            last_valid[n] = 1'b0;
            last_word[n]  = 32'h0;
            gap[n]        = 0;
        end
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            for (int n = 0; n < 3; n++) begin
                drive_slot(n);
            end
            if (count[0] >= NREQ && count[1] >= NREQ && count[2] >= NREQ
                && !busy[0] && !busy[1] && !busy[2]) begin
                break;
            end
        end
        repeat (2) @(posedge clk);
        $display("requests %0d/%0d/%0d, errors %0d", count[0], count[1], count[2], errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // all checks run mid-cycle where DUT outputs are settled
    always @(negedge clk) begin
        logic rdy_now;
        logic [2:0] act;
        if (rst || cyc == 0) begin
            assert (!mem_rd && !slot0_ok && !slot1_ok && !slot2_ok) else begin
                errors++;
                $display("read strobe or ok raised during or right after reset");
            end
        end
        if (cyc >= LIMIT) begin
            $display("timeout after %0d cycles with requests still open", cyc);
            $display("Some tests failed");
            $finish;
        end else if (!rst) begin
            rdy_now  = rdy_pend;
            rdy_pend = mem_valid;
            if (mem_valid) begin
                inflight = 1'b0;
            end
            if (mem_rd) begin
                assert (!inflight) else begin
                    errors++;
                    $display("second read issued while one was still outstanding");
                end
                assert ((cyc % REFRESH_PERIOD) >= REFRESH_CYCLES) else begin
                    errors++;
                    $display("read issued inside a refresh window at cycle %0d", cyc);
                end
                assert (sel >= 0 && {10'h0, mem_addr} == slot_word(sel, cur_addr[sel])) else begin
                    errors++;
                    $display("CHECK FAILED priority: expected slot %0d word %h, actual %h",
                             sel, (sel >= 0) ? slot_word(sel, cur_addr[sel]) : 32'h0,
                             {10'h0, mem_addr});
                end
                rd_cnt[int'({10'h0, mem_addr})] = reads_of({10'h0, mem_addr}) + 1;
                inflight = 1'b1;
            end
            // arbiter model picks slot 0 first and skips the slot just served
            if (sel < 0 || rdy_now) begin
                act = 3'b000;
                for (int n = 0; n < 3; n++) begin
                    act[n] = busy[n] && !filled[n] && (cyc > pres_cyc[n]);
                end
                if (rdy_now && sel >= 0) begin
                    act[sel]    = 1'b0;
                    filled[sel] = 1'b1;
                end
                sel = act[0] ? 0 : act[1] ? 1 : act[2] ? 2 : -1;
            end
            for (int n = 0; n < 3; n++) begin
                if (fresh[n] && hit_exp[n]) begin
                    assert (ok_of(n)) else begin
                        errors++;
                        $display("CHECK FAILED hit slot%0d: expected ok 1, actual %0d",
                                 n, ok_of(n));
                    end
                end
                fresh[n] = 1'b0;
                if (cur_cs[n] && ok_of(n) && busy[n]) begin
                    assert (dout_of(n) == expected_lane(n, cur_addr[n])) else begin
                        errors++;
                        $display("CHECK FAILED data slot%0d addr %h: expected %h, actual %h",
                                 n, cur_addr[n], expected_lane(n, cur_addr[n]), dout_of(n));
                    end
                    if (hit_exp[n]) begin
                        assert (reads_of(slot_word(n, cur_addr[n])) == rd_snap[n]) else begin
                            errors++;
                            $display("CHECK FAILED hit read slot%0d: expected %0d, actual %0d",
                                     n, rd_snap[n], reads_of(slot_word(n, cur_addr[n])));
                        end
                    end
                    last_word[n]  = slot_word(n, cur_addr[n]);
                    last_valid[n] = 1'b1;
                    count[n]      = count[n] + 1;
                    busy[n]       = 1'b0;
                    filled[n]     = 1'b0;
                    done_flag[n]  = 1'b1;
                end
            end
            cyc = cyc + 1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/mem_model.sv ====
/* External memory model for the ROM subsystem testbench.
   Answers each read strobe with one data strobe after 1 to 4 cycles. */
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  wire         clk,
    input  wire         rst,
    input  wire         mem_rd,
    input  wire  [21:0] mem_addr,
    output logic        mem_valid,
    output logic [31:0] mem_data
);

    logic [15:0] lfsr;
    logic        rd_seen;
    logic [21:0] addr_seen;
    logic [21:0] pend_addr;
    logic        busy;
    logic [1:0]  wait_cnt;

    // galois lfsr, one step per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    // fixed mixing of the word address into the stored data
    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [31:0] x;
        x = a * 32'h9E3779B1;
        return x ^ (x >> 15) ^ {a[15:0], a[31:16]};
    endfunction

    initial begin
        mem_valid = 1'b0;
        mem_data  = 32'h0;
        busy      = 1'b0;
        wait_cnt  = 2'd0;
        pend_addr = 22'h0;
        lfsr      = 16'd38833;
        forever begin
            // strobes are sampled mid-cycle, answers driven after the edge
            @(negedge clk);
            rd_seen   = mem_rd && !rst;
            addr_seen = mem_addr;
            @(posedge clk);
            #1;
            mem_valid = 1'b0;
            if (rd_seen) begin
                busy        = 1'b1;
                pend_addr   = addr_seen;
                wait_cnt[0] = next_bit();
                wait_cnt[1] = next_bit();
            end
            if (busy) begin
                if (wait_cnt == 2'd0) begin
                    mem_valid = 1'b1;
                    mem_data  = word_at({10'h0, pend_addr});
                    busy      = 1'b0;
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rom_subsys_top.sv ====
/* Top of the ROM access subsystem: three client slots in front,
   a single-strobe memory read port behind. */
`timescale 1ns/1ps
`default_nettype none

module rom_subsys_top #(
    parameter int SLOT0_DW = 8,
    parameter int SLOT1_DW = 16,
    parameter int SLOT2_DW = 32,
    parameter int SLOT0_AW = 10,
    parameter int SLOT1_AW = 9,
    parameter int SLOT2_AW = 8,
    parameter rom_pkg::sdram_addr_t SLOT0_OFFSET = 22'h000000,
    parameter rom_pkg::sdram_addr_t SLOT1_OFFSET = 22'h001000,
    parameter rom_pkg::sdram_addr_t SLOT2_OFFSET = 22'h002000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [SLOT0_AW-1:0]  slot0_addr,
    input  logic [SLOT1_AW-1:0]  slot1_addr,
    input  logic [SLOT2_AW-1:0]  slot2_addr,
    input  logic                 slot0_cs,
    input  logic                 slot1_cs,
    input  logic                 slot2_cs,
    output logic [SLOT0_DW-1:0]  slot0_dout,
    output logic [SLOT1_DW-1:0]  slot1_dout,
    output logic [SLOT2_DW-1:0]  slot2_dout,
    output logic                 slot0_ok,
    output logic                 slot1_ok,
    output logic                 slot2_ok,
    output logic                 mem_rd,
    output rom_pkg::sdram_addr_t mem_addr,
    input  logic                 mem_valid,
    input  rom_pkg::word_t       mem_data
);
    import rom_pkg::*;

    // arbiter to read controller handshake
    logic        sdram_req;
    logic        sdram_ack;
    sdram_addr_t sdram_addr;
    logic        data_rdy;
    word_t       data_read;

    rom_slot_arbiter #(
        .SLOT0_DW     (SLOT0_DW),
        .SLOT1_DW     (SLOT1_DW),
        .SLOT2_DW     (SLOT2_DW),
        .SLOT0_AW     (SLOT0_AW),
        .SLOT1_AW     (SLOT1_AW),
        .SLOT2_AW     (SLOT2_AW),
        .SLOT0_OFFSET (SLOT0_OFFSET),
        .SLOT1_OFFSET (SLOT1_OFFSET),
        .SLOT2_OFFSET (SLOT2_OFFSET)
    ) arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .slot0_addr (slot0_addr),
        .slot1_addr (slot1_addr),
        .slot2_addr (slot2_addr),
        .slot0_cs   (slot0_cs),
        .slot1_cs   (slot1_cs),
        .slot2_cs   (slot2_cs),
        .slot0_dout (slot0_dout),
        .slot1_dout (slot1_dout),
        .slot2_dout (slot2_dout),
        .slot0_ok   (slot0_ok),
        .slot1_ok   (slot1_ok),
        .slot2_ok   (slot2_ok),
        .sdram_ack  (sdram_ack),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

    sdram_rd_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read),
        .mem_rd     (mem_rd),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data)
    );

endmodule

`default_nettype wire

// ==== hdl/sdram_rd_ctrl.sv ====
/* Read controller between the slot arbiter and the external memory port.
   One read in flight; new reads are held off during refresh windows. */
`timescale 1ns/1ps
`default_nettype none

module sdram_rd_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sdram_req,
    input  rom_pkg::sdram_addr_t sdram_addr,
    output logic                 sdram_ack,
    output logic                 data_rdy,
    output rom_pkg::word_t       data_read,
    output logic                 mem_rd,
    output rom_pkg::sdram_addr_t mem_addr,
    input  logic                 mem_valid,
    input  rom_pkg::word_t       mem_data
);
    import rom_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_t;

    state_t                state;
    logic [REFRESH_CW-1:0] ref_cnt;
    logic                  in_refresh;
    logic                  accept;

    // free-running counter, zero in the first cycle after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ref_cnt <= '0;
        end else if (ref_cnt == REFRESH_CW'(REFRESH_PERIOD - 1)) begin
            ref_cnt <= '0;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    // refresh occupies the first cycles of every period
    assign in_refresh = ref_cnt < REFRESH_CW'(REFRESH_CYCLES);

    assign accept    = (state == ST_IDLE) && sdram_req && !in_refresh;
    assign sdram_ack = accept;
    assign mem_rd    = accept;
    assign mem_addr  = sdram_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            data_rdy <= 1'b0;
        end else begin
            data_rdy <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // refresh may start meanwhile, the pending read still completes
                    if (mem_valid) begin
                        data_rdy <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // returned word, valid together with data_rdy
    always_ff @(posedge clk) begin
        if (mem_valid) begin
            data_read <= mem_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rom_slot_arbiter.sv ====
/* Three cached ROM slots sharing one SDRAM read path.
   Fixed priority, slot 0 wins; one slot is served per read. */
`timescale 1ns/1ps
`default_nettype none

module rom_slot_arbiter #(
    parameter int SLOT0_DW = 8,
    parameter int SLOT1_DW = 16,
    parameter int SLOT2_DW = 32,
    parameter int SLOT0_AW = 10,
    parameter int SLOT1_AW = 9,
    parameter int SLOT2_AW = 8,
    parameter rom_pkg::sdram_addr_t SLOT0_OFFSET = '0,
    parameter rom_pkg::sdram_addr_t SLOT1_OFFSET = '0,
    parameter rom_pkg::sdram_addr_t SLOT2_OFFSET = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [SLOT0_AW-1:0]  slot0_addr,
    input  logic [SLOT1_AW-1:0]  slot1_addr,
    input  logic [SLOT2_AW-1:0]  slot2_addr,
    input  logic                 slot0_cs,
    input  logic                 slot1_cs,
    input  logic                 slot2_cs,
    output logic [SLOT0_DW-1:0]  slot0_dout,
    output logic [SLOT1_DW-1:0]  slot1_dout,
    output logic [SLOT2_DW-1:0]  slot2_dout,
    output logic                 slot0_ok,
    output logic                 slot1_ok,
    output logic                 slot2_ok,
    input  logic                 sdram_ack,
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 data_rdy,
    input  rom_pkg::word_t       data_read
);
    import rom_pkg::*;

    logic [2:0]  req;
    logic [2:0]  slot_sel;
    logic [2:0]  active;
    logic [2:0]  next_sel;
    logic        rearb;
    sdram_addr_t rq_addr0;
    sdram_addr_t rq_addr1;
    sdram_addr_t rq_addr2;
    sdram_addr_t next_addr;

    rom_slot_rq #(.DW(SLOT0_DW), .AW(SLOT0_AW), .OFFSET(SLOT0_OFFSET)) slot0_i (
        .clk        (clk),
        .rst        (rst),
        .addr       (slot0_addr),
        .cs         (slot0_cs),
        .we         (slot_sel[0]),
        .din        (data_read),
        .din_ok     (data_rdy),
        .sdram_addr (rq_addr0),
        .req        (req[0]),
        .dout       (slot0_dout),
        .data_ok    (slot0_ok)
    );

    rom_slot_rq #(.DW(SLOT1_DW), .AW(SLOT1_AW), .OFFSET(SLOT1_OFFSET)) slot1_i (
        .clk        (clk),
        .rst        (rst),
        .addr       (slot1_addr),
        .cs         (slot1_cs),
        .we         (slot_sel[1]),
        .din        (data_read),
        .din_ok     (data_rdy),
        .sdram_addr (rq_addr1),
        .req        (req[1]),
        .dout       (slot1_dout),
        .data_ok    (slot1_ok)
    );

    rom_slot_rq #(.DW(SLOT2_DW), .AW(SLOT2_AW), .OFFSET(SLOT2_OFFSET)) slot2_i (
        .clk        (clk),
        .rst        (rst),
        .addr       (slot2_addr),
        .cs         (slot2_cs),
        .we         (slot_sel[2]),
        .din        (data_read),
        .din_ok     (data_rdy),
        .sdram_addr (rq_addr2),
        .req        (req[2]),
        .dout       (slot2_dout),
        .data_ok    (slot2_ok)
    );

    // the slot just served still shows req in the data_rdy cycle, skip it
    assign active = req & ~slot_sel;
    assign rearb  = (slot_sel == 3'b000) || data_rdy;

    always_comb begin
        next_sel  = 3'b000;
        next_addr = rq_addr0;
        if (active[0]) begin
            next_sel = 3'b001;
        end else if (active[1]) begin
            next_sel  = 3'b010;
            next_addr = rq_addr1;
        end else if (active[2]) begin
            next_sel  = 3'b100;
            next_addr = rq_addr2;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdram_req <= 1'b0;
            slot_sel  <= 3'b000;
        end else if (rearb) begin
            sdram_req <= |active;
            slot_sel  <= next_sel;
        end else if (sdram_ack) begin
            sdram_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rearb) begin
            sdram_addr <= next_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rom_slot_rq.sv ====
/* One ROM client slot with a single-word cache.
   Raises req on a miss and serves 8, 16 or 32-bit lanes of the cached word. */
`timescale 1ns/1ps
`default_nettype none

module rom_slot_rq #(
    parameter int DW = 8,
    parameter int AW = 10,
    parameter rom_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [AW-1:0]        addr,
    input  logic                 cs,
    input  logic                 we,
    input  rom_pkg::word_t       din,
    input  logic                 din_ok,
    output rom_pkg::sdram_addr_t sdram_addr,
    output logic                 req,
    output logic [DW-1:0]        dout,
    output logic                 data_ok
);
    import rom_pkg::*;

    // number of low address bits that pick a lane inside the word
    localparam int SH = (DW == 8) ? 2 : (DW == 16) ? 1 : 0;

    sdram_addr_t word_addr;
    sdram_addr_t tag;
    word_t       cache;
    logic        valid;
    logic        hit;
    logic        fill;

    // slot address counts DW-bit units, scale down to 32-bit words
    assign word_addr  = OFFSET + sdram_addr_t'(addr >> SH);
    assign sdram_addr = word_addr;

    assign hit     = valid && (tag == word_addr);
    assign data_ok = cs && hit;

    // only the slot selected by the arbiter takes the returned word
    assign fill = we && din_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
            req   <= 1'b0;
        end else begin
            if (fill) begin
                valid <= 1'b1;
                req   <= 1'b0;
            end else begin
                // keep asking while the client waits on a missing word
                req <= cs && !hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            cache <= din;
            tag   <= word_addr;
        end
    end

    // little-endian lane selection
    generate
        if (SH == 0) begin : g_full
            assign dout = cache;
        end else begin : g_lane
            logic [SH-1:0] lane;

            assign lane = addr[SH-1:0];
            assign dout = cache[lane*DW +: DW];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/rom_pkg.sv ====
/* Shared types and refresh constants for the ROM access subsystem.
   Imported by every RTL module that needs an SDRAM address or data word. */
`default_nettype none

package rom_pkg;

    // width of a 32-bit word address into the SDRAM
    localparam int SDRAM_AW = 22;

    typedef logic [SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [31:0]         word_t;

    // cycles between the starts of two refresh windows
    localparam int REFRESH_PERIOD = 64;
    // refresh window length, no read is accepted inside it
    localparam int REFRESH_CYCLES = 6;
    // width of the free-running refresh counter
    localparam int REFRESH_CW = $clog2(REFRESH_PERIOD);

endpackage

`default_nettype wire
